/* Bender.yml */
package:
  name: exu

sources:
  - design/exu_pkg.sv
  - design/alu_shifter.sv
  - design/alu_int.sv
  - design/muldiv_ctrl.sv
  - design/muldiv_counter.sv
  - design/muldiv_datapath.sv
  - design/exu_top.sv
  - target: test
    files:
      - tests/tb_clkgen.sv
      - tests/exu_tb.sv

/* design/alu_int.sv */
`timescale 1ns/1ps

module alu_int (
    input  exu_pkg::alu_op_t op_i,
    input  exu_pkg::xword_t  src1_i,
    input  exu_pkg::xword_t  src2_i,
    output exu_pkg::xword_t  result_o,
    output logic             zero_o
);

    logic [2:0]      fn;
    logic            variant;
    logic            word;
    logic            is_cmp;
    logic            sub;
    logic            carry;
    logic            overflow;
    logic            less;
    exu_pkg::xword_t b_in;
    exu_pkg::xword_t sum;
    exu_pkg::xword_t shift;
    exu_pkg::xword_t alu_out;

    assign fn      = op_i[2:0];
    assign variant = op_i[3];
    assign word    = op_i[4];

    // compares always subtract, add only with the variant bit
    assign is_cmp = (fn == exu_pkg::FN_SLT);
    assign sub    = is_cmp | ((fn == exu_pkg::FN_ADD) & variant);

    assign b_in = src2_i ^ {exu_pkg::xlen{sub}};

    assign {carry, sum} = {1'b0, src1_i} + {1'b0, b_in} + {{exu_pkg::xlen{1'b0}}, sub};

    assign overflow = (src1_i[exu_pkg::xlen-1] == b_in[exu_pkg::xlen-1]) &&
                      (sum[exu_pkg::xlen-1] != src1_i[exu_pkg::xlen-1]);

    // unsigned: no carry out of a - b means a < b
    assign less = variant ? ~carry : (sum[exu_pkg::xlen-1] ^ overflow);

    assign zero_o = ~|sum;

    alu_shifter u_shifter (
        .shamt_i (src2_i[5:0]),
        .src_i   (src1_i),
        .word_i  (word),
        .right_i (fn[2]),
        .arith_i (variant),
        .shift_o (shift)
    );

    always_comb begin
        case (fn)
            exu_pkg::FN_ADD: begin
                alu_out = sum;
            end
            exu_pkg::FN_SLL, exu_pkg::FN_SR: begin
                alu_out = shift;
            end
            exu_pkg::FN_SLT: begin
                alu_out = {{(exu_pkg::xlen-1){1'b0}}, less};
            end
            exu_pkg::FN_SRC2: begin
                alu_out = src2_i;
            end
            exu_pkg::FN_XOR: begin
                alu_out = src1_i ^ src2_i;
            end
            exu_pkg::FN_OR: begin
                alu_out = src1_i | src2_i;
            end
            default: begin
                alu_out = src1_i & src2_i;
            end
        endcase
    end

    // word forms keep 32 bits, sign-extended
    assign result_o = word ? {{32{alu_out[31]}}, alu_out[31:0]} : alu_out;

endmodule

/* design/alu_shifter.sv */
`timescale 1ns/1ps

module alu_shifter (
    input  exu_pkg::shamt_t shamt_i,
    input  exu_pkg::xword_t src_i,
    input  logic            word_i,
    input  logic            right_i,
    input  logic            arith_i,
    output exu_pkg::xword_t shift_o
);

    function automatic exu_pkg::xword_t bit_rev(input exu_pkg::xword_t v);
        exu_pkg::xword_t r;
        for (int i = 0; i < exu_pkg::xlen; i++) begin
            r[i] = v[exu_pkg::xlen-1-i];
        end
        return r;
    endfunction

    exu_pkg::shamt_t amt;
    exu_pkg::xword_t right_src;
    exu_pkg::xword_t shft_src;
    exu_pkg::xword_t shft_res;
    exu_pkg::xword_t fill_mask;
    logic            fill_bit;

    // word shifts only use the low five bits of the amount
    assign amt = word_i ? {1'b0, shamt_i[4:0]} : shamt_i;

    // word right shifts work on the low half,
    // upper half pre-filled with bit 31 or zeros
    assign right_src = word_i ? {{32{arith_i & src_i[31]}}, src_i[31:0]} : src_i;

    // left shift = reverse, shift right, reverse back
    assign shft_src = right_i ? right_src : bit_rev(src_i);

    assign shft_res = shft_src >> amt;

    // vacated upper bits for arithmetic shifts
    assign fill_mask = ~({exu_pkg::xlen{1'b1}} >> amt);
    assign fill_bit  = right_i & arith_i & right_src[exu_pkg::xlen-1];

    always_comb begin
        if (right_i) begin
            shift_o = shft_res | (fill_mask & {exu_pkg::xlen{fill_bit}});
        end else begin
            shift_o = bit_rev(shft_res);
        end
    end

endmodule

/* design/exu_pkg.sv */
package exu_pkg;

    // operand and result width
    localparam int xlen = 64;

    typedef logic [xlen-1:0] xword_t;

    // alu opcode: [4] word form, [3] variant, [2:0] function
    typedef logic [4:0] alu_op_t;

    // muldiv selector, bit 2 set for divide and remainder
    typedef logic [2:0] md_sel_t;

    typedef logic [5:0] shamt_t;

    typedef logic [6:0] step_cnt_t;

    // function field of the alu opcode
    localparam logic [2:0] FN_ADD  = 3'b000;
    localparam logic [2:0] FN_SLL  = 3'b001;
    localparam logic [2:0] FN_SLT  = 3'b010;
    localparam logic [2:0] FN_SRC2 = 3'b011;
    localparam logic [2:0] FN_XOR  = 3'b100;
    localparam logic [2:0] FN_SR   = 3'b101;
    localparam logic [2:0] FN_OR   = 3'b110;
    localparam logic [2:0] FN_AND  = 3'b111;

    // full opcodes, 64-bit forms
    // set bit 4 for the word variant
    localparam alu_op_t ALU_ADD  = 5'b00000;
    localparam alu_op_t ALU_SUB  = 5'b01000;
    localparam alu_op_t ALU_SLL  = 5'b00001;
    localparam alu_op_t ALU_SLT  = 5'b00010;
    localparam alu_op_t ALU_SLTU = 5'b01010;
    localparam alu_op_t ALU_SRC2 = 5'b00011;
    localparam alu_op_t ALU_XOR  = 5'b00100;
    localparam alu_op_t ALU_SRL  = 5'b00101;
    localparam alu_op_t ALU_SRA  = 5'b01101;
    localparam alu_op_t ALU_OR   = 5'b00110;
    localparam alu_op_t ALU_AND  = 5'b00111;

    // same order as funct3 of the M extension
    localparam md_sel_t MD_MUL    = 3'b000;
    localparam md_sel_t MD_MULH   = 3'b001;
    localparam md_sel_t MD_MULHSU = 3'b010;
    localparam md_sel_t MD_MULHU  = 3'b011;
    localparam md_sel_t MD_DIV    = 3'b100;
    localparam md_sel_t MD_DIVU   = 3'b101;
    localparam md_sel_t MD_REM    = 3'b110;
    localparam md_sel_t MD_REMU   = 3'b111;

    // one result bit per iteration
    localparam step_cnt_t md_steps = 7'd64;

endpackage

/* design/exu_top.sv */
`timescale 1ns/1ps

module exu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_i,
    input  exu_pkg::alu_op_t op_i,
    input  logic             md_en_i,
    input  exu_pkg::md_sel_t md_sel_i,
    input  exu_pkg::xword_t  src1_i,
    input  exu_pkg::xword_t  src2_i,
    input  logic             flush_i,
    output logic             ack_o,
    output exu_pkg::xword_t  result_o,
    output logic             zero_o
);

    exu_pkg::xword_t alu_result;
    exu_pkg::xword_t md_result;
    logic            md_start;
    logic            md_step;
    logic            md_finish;
    logic            cnt_load;
    logic            cnt_clear;
    logic            cnt_last;

    // combinational integer ops
    alu_int u_alu (
        .op_i     (op_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .result_o (alu_result),
        .zero_o   (zero_o)
    );

    // handshake and result register
    muldiv_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_i),
        .md_en_i      (md_en_i),
        .flush_i      (flush_i),
        .alu_result_i (alu_result),
        .md_result_i  (md_result),
        .cnt_last_i   (cnt_last),
        .md_start_o   (md_start),
        .md_step_o    (md_step),
        .md_finish_o  (md_finish),
        .cnt_load_o   (cnt_load),
        .cnt_clear_o  (cnt_clear),
        .ack_o        (ack_o),
        .result_o     (result_o)
    );

    muldiv_counter u_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .load_i  (cnt_load),
        .en_i    (md_step),
        .clear_i (cnt_clear),
        .last_o  (cnt_last)
    );

    muldiv_datapath u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (md_start),
        .step_i   (md_step),
        .finish_i (md_finish),
        .sel_i    (md_sel_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .result_o (md_result)
    );

endmodule

/* design/muldiv_counter.sv */
`timescale 1ns/1ps

module muldiv_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic load_i,
    input  logic en_i,
    input  logic clear_i,
    output logic last_o
);

    exu_pkg::step_cnt_t cnt;

    // counts down from md_steps, one per iteration
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (clear_i) begin
            cnt <= '0;
        end else if (load_i) begin
            cnt <= exu_pkg::md_steps;
        end else if (en_i && cnt != '0) begin
            cnt <= cnt - 7'd1;
        end
    end

    // high during the final iteration
    assign last_o = en_i && (cnt == 7'd1);

endmodule

/* design/muldiv_ctrl.sv */
`timescale 1ns/1ps

module muldiv_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_i,
    input  logic            md_en_i,
    input  logic            flush_i,
    input  exu_pkg::xword_t alu_result_i,
    input  exu_pkg::xword_t md_result_i,
    input  logic            cnt_last_i,
    output logic            md_start_o,
    output logic            md_step_o,
    output logic            md_finish_o,
    output logic            cnt_load_o,
    output logic            cnt_clear_o,
    output logic            ack_o,
    output exu_pkg::xword_t result_o
);

    typedef enum logic [2:0] {IDLE, ALU_CAP, MD_RUN, MD_FIN, ACK, WAIT_REL} state_t;

    state_t state;
    state_t state_nxt;
    logic   flush_acc;
    logic   capture;

    // flush is ignored once ack is up
    assign flush_acc = flush_i & ~ack_o;

    assign md_start_o  = (state == IDLE) & req_i & md_en_i & ~flush_acc;
    assign cnt_load_o  = md_start_o;
    assign md_step_o   = (state == MD_RUN) & ~flush_acc;
    assign md_finish_o = (state == MD_FIN) & ~flush_acc;
    assign cnt_clear_o = flush_acc;

    // alu result in ALU_CAP, muldiv result one cycle after finish
    assign capture = (state == ALU_CAP) | ((state == ACK) & md_en_i);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (req_i) state_nxt = md_en_i ? MD_RUN : ALU_CAP;
            ALU_CAP:  state_nxt = ACK;
            MD_RUN:   if (cnt_last_i) state_nxt = MD_FIN;
            MD_FIN:   state_nxt = ACK;
            ACK:      state_nxt = WAIT_REL;
            default:  if (!req_i) state_nxt = IDLE;
        endcase
        // aborted op still waits for req to drop
        if (flush_acc) state_nxt = WAIT_REL;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            ack_o    <= 1'b0;
            result_o <= '0;
        end else begin
            state <= state_nxt;
            if (capture && !flush_acc) begin
                result_o <= md_en_i ? md_result_i : alu_result_i;
            end
            if (state == ACK) begin
                ack_o <= ~flush_acc;
            end else if (state == WAIT_REL && !req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

endmodule

/* design/muldiv_datapath.sv */
`timescale 1ns/1ps

module muldiv_datapath (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_i,
    input  logic             step_i,
    input  logic             finish_i,
    input  exu_pkg::md_sel_t sel_i,
    input  exu_pkg::xword_t  src1_i,
    input  exu_pkg::xword_t  src2_i,
    output exu_pkg::xword_t  result_o
);

    logic            is_div;
    logic            a_signed;
    logic            b_signed;
    logic            a_neg;
    logic            b_neg;
    exu_pkg::xword_t a_mag;
    exu_pkg::xword_t b_mag;
    exu_pkg::xword_t mcand;
    logic [127:0]    acc;
    logic [64:0]     mul_sum;
    logic [64:0]     div_tmp;
    logic [65:0]     div_diff;
    logic            neg_q;
    logic            neg_r;
    logic            div_zero;
    logic            div_ovf;
    logic [127:0]    prod_fix;
    exu_pkg::xword_t quo_fix;
    exu_pkg::xword_t rem_fix;
    exu_pkg::xword_t final_res;

    assign is_div   = sel_i[2];
    assign a_signed = (sel_i == exu_pkg::MD_MULH) | (sel_i == exu_pkg::MD_MULHSU) |
                      (sel_i == exu_pkg::MD_DIV) | (sel_i == exu_pkg::MD_REM);
    assign b_signed = (sel_i == exu_pkg::MD_MULH) | (sel_i == exu_pkg::MD_DIV) |
                      (sel_i == exu_pkg::MD_REM);
    assign a_neg = a_signed & src1_i[63];
    assign b_neg = b_signed & src2_i[63];
    assign a_mag = a_neg ? -src1_i : src1_i;
    assign b_mag = b_neg ? -src2_i : src2_i;

    // multiply: acc holds {partial high, multiplier}, add mcand on bit 0
    assign mul_sum = {1'b0, acc[127:64]} + (acc[0] ? {1'b0, mcand} : 65'd0);
    // divide: acc holds {remainder, quotient}, mcand is the divisor
    assign div_tmp  = {acc[127:64], acc[63]};
    assign div_diff = {1'b0, div_tmp} - {2'b00, mcand};

    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand <= is_div ? b_mag : a_mag;
            acc   <= {64'd0, is_div ? a_mag : b_mag};
        end else if (step_i) begin
            if (!is_div) begin
                acc <= {mul_sum, acc[63:1]};
            end else if (div_diff[65]) begin
                // restore, quotient bit zero
                acc <= {div_tmp[63:0], acc[62:0], 1'b0};
            end else begin
                acc <= {div_diff[63:0], acc[62:0], 1'b1};
            end
        end
    end

    assign prod_fix = neg_q ? -acc : acc;
    assign quo_fix  = neg_q ? -acc[63:0] : acc[63:0];
    // remainder takes the sign of the dividend
    assign rem_fix  = neg_r ? -acc[127:64] : acc[127:64];

    always_comb begin
        case (sel_i)
            exu_pkg::MD_MUL:                   final_res = prod_fix[63:0];
            exu_pkg::MD_DIV, exu_pkg::MD_DIVU: final_res = div_zero ? '1 :
                                                           div_ovf ? src1_i : quo_fix;
            exu_pkg::MD_REM, exu_pkg::MD_REMU: final_res = div_zero ? src1_i :
                                                           div_ovf ? '0 : rem_fix;
            default:                           final_res = prod_fix[127:64];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            neg_q    <= 1'b0;
            neg_r    <= 1'b0;
            div_zero <= 1'b0;
            div_ovf  <= 1'b0;
            result_o <= '0;
        end else begin
            if (start_i) begin
                neg_q    <= a_neg ^ b_neg;
                neg_r    <= a_neg;
                div_zero <= is_div & (src2_i == '0);
                // most negative value divided by minus one
                div_ovf  <= b_signed & is_div & (src1_i == {1'b1, 63'd0}) & (src2_i == '1);
            end
            if (finish_i) result_o <= final_res;
        end
    end

endmodule

/* files.f */
design/exu_pkg.sv
design/alu_shifter.sv
design/alu_int.sv
design/muldiv_ctrl.sv
design/muldiv_counter.sv
design/muldiv_datapath.sv
design/exu_top.sv
tests/tb_clkgen.sv
tests/exu_tb.sv

/* tests/exu_stim.txt */
alu 00 0000000000000005 0000000000000003 0000000000000008 0
alu 08 0000000000000010 0000000000000010 0000000000000000 1
alu 04 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0
alu 07 123456789abcdef0 ff00ff00ff00ff00 120056009a00de00 0
alu 03 1111111111111111 eeeeeeeeeeeeeeef eeeeeeeeeeeeeeef 1
alu 02 8000000000000000 0000000000000001 0000000000000001 0
alu 0a 8000000000000000 0000000000000001 0000000000000000 0
alu 01 0000000000000001 0000000000000000 0000000000000001 0
alu 01 0000000000000001 000000000000003f 8000000000000000 0
alu 05 8000000000000000 0000000000000001 4000000000000000 0
alu 0d 8000000000000000 000000000000001f ffffffff00000000 0
alu 0d 7000000000000000 0000000000000020 0000000070000000 0
alu 10 000000007fffffff 0000000000000001 ffffffff80000000 0
alu 18 0000000100000000 0000000000000001 ffffffffffffffff 0
alu 11 0000000000000001 000000000000001f ffffffff80000000 0
alu 15 ffffffff80000000 0000000000000004 0000000008000000 0
alu 1d 0000000080000000 0000000000000004 fffffffff8000000 0
md 0 fffffffffffffffd 0000000000000003 fffffffffffffff7 0
md 1 8000000000000000 0000000000000002 ffffffffffffffff 0
md 2 ffffffffffffffff 0000000000000002 ffffffffffffffff 0
md 3 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0
md 4 fffffffffffffff9 0000000000000002 fffffffffffffffd 0
md 6 fffffffffffffff9 0000000000000002 ffffffffffffffff 0
md 4 0000000000001234 0000000000000000 ffffffffffffffff 0
md 6 0000000000001234 0000000000000000 0000000000001234 0
md 4 8000000000000000 ffffffffffffffff 8000000000000000 0
md 6 8000000000000000 ffffffffffffffff 0000000000000000 0
flush 4 0000000000000064 0000000000000007 0000000000000000 0
md 5 0000000000000064 0000000000000007 000000000000000e 0
md 7 0000000000000064 0000000000000007 0000000000000002 0

/* tests/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb;

    localparam int tmo_cycles = 200;

    logic             clk;
    logic             rst_n;
    logic             req;
    exu_pkg::alu_op_t op;
    logic             md_en;
    exu_pkg::md_sel_t md_sel;
    exu_pkg::xword_t  src1;
    exu_pkg::xword_t  src2;
    logic             flush;
    logic             ack;
    exu_pkg::xword_t  result;
    logic             zero;
    integer           seed;
    int               errors;
    int               tests;
    int               failed;
    bit               stop;

    tb_clkgen u_clkgen (
        .clk_o (clk)
    );

    exu_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (req),
        .op_i     (op),
        .md_en_i  (md_en),
        .md_sel_i (md_sel),
        .src1_i   (src1),
        .src2_i   (src2),
        .flush_i  (flush),
        .ack_o    (ack),
        .result_o (result),
        .zero_o   (zero)
    );

    task automatic check(input string name, input exu_pkg::xword_t got,
                         input exu_pkg::xword_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // inputs change and outputs are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ack(input logic level);
        for (int n = 0; n < tmo_cycles && ack !== level; n++) begin
            next_cycle();
        end
        if (ack !== level) begin
            $display("timed out waiting for ack_o to go to %0d", level);
            errors++;
            stop = 1'b1;
        end
    endtask

    // one four-phase transfer, or a divide that gets flushed midway
    task automatic run_op(input logic is_md, input logic do_flush, input logic [4:0] code,
                          input exu_pkg::xword_t a, input exu_pkg::xword_t b,
                          input exu_pkg::xword_t exp_res, input logic exp_zero);
        op     = is_md ? 5'd0 : code;
        md_en  = is_md;
        md_sel = code[2:0];
        src1   = a;
        src2   = b;
        req    = 1'b1;
        if (do_flush) begin
            repeat (2 + ($unsigned($random(seed)) % 40)) next_cycle();
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
            // watch past the point where the divide would have finished
            for (int n = 0; n < 70 && ack === 1'b0; n++) begin
                next_cycle();
            end
            check("ack_o", ack, 1'b0);
            req = 1'b0;
            next_cycle();
        end else begin
            wait_ack(1'b1);
            if (!stop) begin
                check("result_o", result, exp_res);
                if (!is_md) begin
                    check("zero_o", zero, exp_zero);
                end
                // slow requester, ack and result hold
                repeat (3) next_cycle();
                check("ack_o", ack, 1'b1);
                check("result_o", result, exp_res);
                req = 1'b0;
                wait_ack(1'b0);
            end
        end
    endtask

    // runs one vector and prints its outcome
    task automatic run_vector(input string kind, input logic [4:0] code,
                              input exu_pkg::xword_t a, input exu_pkg::xword_t b,
                              input exu_pkg::xword_t exp_res, input logic exp_zero);
        int err_before;
        err_before = errors;
        run_op(kind != "alu", kind == "flush", code, a, b, exp_res, exp_zero);
        tests++;
        if (errors != err_before) begin
            failed++;
        end
        $display("test %0d: %s %h %s", tests, kind, code,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int              fd;
        int              exp_zero;
        string           kind;
        logic [4:0]      code;
        exu_pkg::xword_t a;
        exu_pkg::xword_t b;
        exu_pkg::xword_t exp_res;

        seed   = 32'he7ed;
        errors = 0;
        tests  = 0;
        failed = 0;
        stop   = 1'b0;
        rst_n  = 1'b0;
        {req, op, md_en, md_sel, src1, src2, flush} = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("ack_o", ack, 1'b0);
        check("result_o", result, '0);

        // kind, opcode or selector, src1, src2, result, zero flag
        fd = $fopen("tests/exu_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/exu_stim.txt");
            stop = 1'b1;
        end
        while (!stop &&
               $fscanf(fd, "%s %h %h %h %h %d", kind, code, a, b, exp_res, exp_zero) == 6) begin
            run_vector(kind, code, a, b, exp_res, exp_zero[0]);
        end
        if (fd != 0) begin
            if (!stop && !$feof(fd)) begin
                $display("stimulus file has a line that cannot be read");
                errors++;
            end
            $fclose(fd);
        end

        // or, and a high product with a zero operand and a negative one
        if (!stop) begin
            run_vector("alu", exu_pkg::ALU_OR, 64'h123456789abcdef0, 64'h00ff00ff00ff00ff,
                       64'h12ff56ff9affdeff, 1'b0);
        end
        if (!stop) begin
            run_vector("md", {2'b00, exu_pkg::MD_MULH}, 64'h0000000000000000,
                       64'h8000000000000000, 64'h0000000000000000, 1'b0);
        end

        $display("%0d tests, %0d with errors, %0d errors in total", tests, failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tests/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

endmodule
